// ==== bench/tb_mem_mul_tasks.svh ====
`ifndef TB_MEM_MUL_TASKS_SVH
`define TB_MEM_MUL_TASKS_SVH

////////////////////
// Lane math of the reference model

// Each U value lands in the top bits of its lane
function automatic word_t encode_row(input u_row_t u);
  word_t r;
  for (int j = 0; j < LANES; j++) begin
    r[j*LB +: LB] = lane_t'(u[j*UB +: UB]) << (LB - UB);
  end
  return r;
endfunction

function automatic word_t add_lanes(input word_t a, input word_t b);
  word_t r;
  for (int j = 0; j < LANES; j++) begin
    r[j*LB +: LB] = a[j*LB +: LB] + b[j*LB +: LB];
  end
  return r;
endfunction

function automatic word_t sub_lanes(input word_t a, input word_t b);
  word_t r;
  for (int j = 0; j < LANES; j++) begin
    r[j*LB +: LB] = a[j*LB +: LB] - b[j*LB +: LB];
  end
  return r;
endfunction

task automatic check_value(input string name, input word_t exp, input word_t got);
  assert (got === exp) else begin
    value_errs++;
    $display("ERR %s expected 0x%h actual 0x%h at %0t", name, exp, got, $time);
  end
endtask

////////////////////
// Stream helpers

// Holds cmd_is_ready until the command is taken
task automatic send_cmd(input cmd_code_e code);
  @(posedge clk);
  cmd <= code;
  cmd_is_ready <= 1'b1;
  @(negedge clk);
  while (!cmd_can_receive) begin
    @(negedge clk);
  end
  @(posedge clk);
  cmd_is_ready <= 1'b0;
endtask

task automatic stream_rows(input cmd_code_e code);
  word_t w;
  for (int i = 0; i < ROWS; i++) begin
    w = {$urandom, $urandom};
    @(posedge clk);
    in_data <= w;
    in_is_ready <= 1'b1;
    @(negedge clk);
    while (!in_can_receive) begin
      @(negedge clk);
    end
    check_value("in_is_last", word_t'(i == ROWS - 1), word_t'(in_is_last));
    case (code)
      CMD_IN_C: c_model[i] = w;
      CMD_IN_U: u_model[i] = w[U_ROW_BITS-1:0];
      CMD_C_ADD_IN: c_model[i] = add_lanes(c_model[i], w);
      default: ;
    endcase
  end
  @(posedge clk);
  in_is_ready <= 1'b0;
endtask

// Throttle drops out_can_receive about two cycles in three
task automatic collect_rows(input bit from_u, input bit throttle);
  int taken;
  word_t exp;
  taken = 0;
  while (taken < ROWS) begin
    @(posedge clk);
    if (throttle) begin
      out_can_receive <= ($urandom % 3) == 0;
    end else begin
      out_can_receive <= 1'b1;
    end
    @(negedge clk);
    if (out_is_ready) begin
      exp = from_u ? word_t'(u_model[taken]) : c_model[taken];
      check_value("out", exp, out_data);
      check_value("out_is_last", word_t'(taken == ROWS - 1), word_t'(out_is_last));
      taken++;
    end else begin
      check_value("out_is_last", 64'h0, word_t'(out_is_last));
    end
  end
  @(posedge clk);
  out_can_receive <= 1'b1;
endtask

////////////////////
// Directed tests

task automatic check_reset_state();
  @(negedge clk);
  check_value("cmd_can_receive", 64'h1, word_t'(cmd_can_receive));
  check_value("in_can_receive", 64'h0, word_t'(in_can_receive));
  check_value("in_is_last", 64'h0, word_t'(in_is_last));
  check_value("out_is_ready", 64'h0, word_t'(out_is_ready));
  check_value("out_is_last", 64'h0, word_t'(out_is_last));
endtask

task automatic test_load_unload_c();
  $display("Running load C and unload C");
  send_cmd(CMD_IN_C);
  stream_rows(CMD_IN_C);
  send_cmd(CMD_OUT_C);
  collect_rows(1'b0, 1'b0);
endtask

task automatic test_load_unload_u();
  $display("Running load U and unload U");
  send_cmd(CMD_IN_U);
  stream_rows(CMD_IN_U);
  send_cmd(CMD_OUT_U);
  collect_rows(1'b1, 1'b0);
endtask

task automatic test_encode();
  $display("Running C = Encode(U)");
  send_cmd(CMD_C_EQ_U);
  for (int i = 0; i < ROWS; i++) begin
    c_model[i] = encode_row(u_model[i]);
  end
  send_cmd(CMD_OUT_C);
  collect_rows(1'b0, 1'b0);
endtask

task automatic test_encode_minus();
  $display("Running C = Encode(U) - C");
  send_cmd(CMD_C_EQ_U_MIN_C);
  for (int i = 0; i < ROWS; i++) begin
    c_model[i] = sub_lanes(encode_row(u_model[i]), c_model[i]);
  end
  send_cmd(CMD_OUT_C);
  collect_rows(1'b0, 1'b0);
endtask

task automatic test_add_stream();
  $display("Running C += streamed rows");
  send_cmd(CMD_C_ADD_IN);
  stream_rows(CMD_C_ADD_IN);
  send_cmd(CMD_OUT_C);
  collect_rows(1'b0, 1'b0);
endtask

// Unload C under back-pressure while load U runs in the other class
task automatic test_unload_with_load();
  $display("Running unload C with back-pressure and a parallel load U");
  @(posedge clk);
  out_can_receive <= 1'b0;
  unload_done = 1'b0;
  send_cmd(CMD_OUT_C);
  send_cmd(CMD_IN_U);
  fork
    begin
      collect_rows(1'b0, 1'b1);
      unload_done = 1'b1;
    end
    begin
      stream_rows(CMD_IN_U);
      assert (!unload_done) else begin
        flow_errs++;
        $display("Load U did not finish while the unload was still running");
      end
    end
  join
  // Nothing may follow the sixteenth word
  repeat (4) begin
    @(negedge clk);
    assert (!out_is_ready) else begin
      flow_errs++;
      $display("Extra output word appeared after the unload ended at %0t", $time);
    end
  end
  send_cmd(CMD_OUT_U);
  collect_rows(1'b1, 1'b0);
endtask

`endif

// ==== bench/tb_mem_mul.sv ====
`timescale 1ns/1ps
`include "mem_mul_consts.svh"

module tb_mem_mul
  import mem_mul_cmd_pkg::*;
  import mem_mul_data_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 8;
  localparam int ROWS = `MM_ROWS;
  localparam int LANES = `MM_LANES;
  localparam int LB = `MM_LANE_BITS;
  localparam int UB = `MM_U_BITS;
  localparam int U_ROW_BITS = `MM_LANES * `MM_U_BITS;
  // Ten command sequences, none longer than 200 cycles
  localparam int SEQ_COUNT = 10;
  localparam int SEQ_CYCLES = 200;
  localparam int WATCHDOG_NS = SEQ_COUNT * SEQ_CYCLES * CLK_PERIOD;

  logic clk = 1'b0;
  logic rst_n;
  cmd_code_e cmd;
  logic cmd_is_ready;
  logic cmd_can_receive;
  word_t in_data;
  logic in_is_ready;
  logic in_can_receive;
  logic in_is_last;
  word_t out_data;
  logic out_is_ready;
  logic out_is_last;
  logic out_can_receive;

  // Reference contents of both stores
  word_t c_model [ROWS];
  u_row_t u_model [ROWS];

  int value_errs;
  int flow_errs;
  bit unload_done;

  mem_mul_top UUT (
    .cmd(cmd),
    .cmd_is_ready(cmd_is_ready),
    .cmd_can_receive(cmd_can_receive),
    .in(in_data),
    .in_is_ready(in_is_ready),
    .in_can_receive(in_can_receive),
    .in_is_last(in_is_last),
    .out(out_data),
    .out_is_ready(out_is_ready),
    .out_is_last(out_is_last),
    .out_can_receive(out_can_receive),
    .clk(clk),
    .rst_n(rst_n)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  `include "tb_mem_mul_tasks.svh"

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, test sequence did not finish", WATCHDOG_NS);
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////
  // Test sequence
  initial begin
    void'($urandom(55402));
    value_errs = 0;
    flow_errs = 0;
    unload_done = 1'b0;
    rst_n <= 1'b0;
    cmd <= CMD_IN_C;
    cmd_is_ready <= 1'b0;
    in_data <= '0;
    in_is_ready <= 1'b0;
    out_can_receive <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    check_reset_state();
    test_load_unload_c();
    test_load_unload_u();
    // C still holds the random rows from the load test here
    test_encode_minus();
    test_encode();
    test_add_stream();
    test_unload_with_load();

    $display("Checks done: %0d value errors, %0d flow errors", value_errs, flow_errs);
    if (value_errs + flow_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_mem_mul -Mdir obj_dir \
  && ./obj_dir/Vtb_mem_mul > sim.log 2>&1 \
  || { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^TEST PASS$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== source/cmd_dispatch.sv ====
`timescale 1ns/1ps
`include "mem_mul_consts.svh"

module cmd_dispatch
  import mem_mul_cmd_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input cmd_code_e cmd,
  input logic cmd_is_ready,
  output logic cmd_can_receive,
  cmd_status_if.dispatch status
);

  logic buf_valid;
  cmd_code_e buf_code;
  logic pend_any;
  cmd_code_e pend_code;
  cmd_onehot_t pend_onehot;
  logic pend_wait;
  logic consume;
  cmd_onehot_t prev_cmd;
  cmd_onehot_t cur_cmd;
  cmd_onehot_t next_cmd;

  ////////////////////
  // One-entry buffer, bypassed when empty
  assign cmd_can_receive = ~buf_valid;
  assign pend_any = buf_valid | cmd_is_ready;
  assign pend_code = buf_valid ? buf_code : cmd;
  assign pend_onehot = cmd_onehot_t'(1) << pend_code;

  // Wait while a class of the pending command is busy
  assign pend_wait = ((|(pend_onehot & `MM_MASK_IN_CLASS)) & (|(prev_cmd & `MM_MASK_IN_CLASS)))
                   | ((|(pend_onehot & `MM_MASK_OUT_CLASS)) & (|(prev_cmd & `MM_MASK_OUT_CLASS)));
  assign consume = pend_any & ~pend_wait;

  assign cur_cmd = prev_cmd | (consume ? pend_onehot : '0);
  assign status.cur_cmd = cur_cmd;
  assign status.in_first = |(cur_cmd & ~prev_cmd & `MM_MASK_IN_CLASS);
  assign status.out_first = |(cur_cmd & ~prev_cmd & `MM_MASK_OUT_CLASS);

  // Drop a class on its last cycle
  assign next_cmd = cur_cmd
                  & ~({`MM_CMD_COUNT{status.in_last}} & `MM_MASK_IN_CLASS)
                  & ~({`MM_CMD_COUNT{status.out_last}} & `MM_MASK_OUT_CLASS);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_cmd <= '0;
      buf_valid <= 1'b0;
    end else begin
      prev_cmd <= next_cmd;
      if (!buf_valid && cmd_is_ready && !consume) begin
        buf_valid <= 1'b1;
      end else if (buf_valid && consume) begin
        buf_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!buf_valid && cmd_is_ready) begin
      buf_code <= cmd;
    end
  end

endmodule

// ==== source/index_handler.sv ====
`timescale 1ns/1ps
`include "mem_mul_consts.svh"

module index_handler
  import mem_mul_cmd_pkg::*;
  import mem_mul_data_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic in_is_ready,
  input logic out_can_receive,
  output logic in_can_receive,
  output logic in_is_last,
  cmd_status_if.worker status,
  row_mem_if.indexer mem
);

  localparam int LAT = `MM_READ_LATENCY;
  localparam row_index_t LAST_ROW = row_index_t'(`MM_ROWS - 1);

  logic is_load;
  logic is_unload;
  logic is_enc;
  logic is_add;
  logic is_op;
  logic unload_rd;
  logic op_rd;
  logic rd_open;
  logic rd_open_q;
  row_index_t r_idx;
  row_index_t r_cnt_q;
  logic ld_first;
  logic ld_wr;
  row_index_t ld_idx;
  row_index_t ld_cnt_q;
  logic [LAT-1:0] op_we_q;
  logic [LAT-1:0] op_last_q;
  row_index_t op_widx_q [LAT];

  assign is_load = status.cur_cmd[CMD_IN_C] | status.cur_cmd[CMD_IN_U];
  assign is_unload = status.cur_cmd[CMD_OUT_C] | status.cur_cmd[CMD_OUT_U];
  assign is_enc = status.cur_cmd[CMD_C_EQ_U] | status.cur_cmd[CMD_C_EQ_U_MIN_C];
  assign is_add = status.cur_cmd[CMD_C_ADD_IN];
  assign is_op = is_enc | is_add;

  ////////////////////
  // Read row counter, shared by unloads and operations
  assign r_idx = status.out_first ? '0 : r_cnt_q;
  assign rd_open = ((status.in_first & is_op) | rd_open_q) & is_op;
  assign unload_rd = is_unload & out_can_receive;
  assign op_rd = (is_enc & rd_open) | (is_add & rd_open & in_is_ready);

  assign in_can_receive = is_load | (is_add & rd_open);

  assign mem.r_index = r_idx;
  assign mem.r_c_sel = (status.cur_cmd[CMD_OUT_C] & out_can_receive)
                     | ((status.cur_cmd[CMD_C_EQ_U_MIN_C] | is_add) & op_rd);
  assign mem.r_u_sel = (status.cur_cmd[CMD_OUT_U] & out_can_receive) | (is_enc & op_rd);

  ////////////////////
  // Load writes land in the cycle the word is taken
  assign ld_first = status.in_first & is_load;
  assign ld_idx = ld_first ? '0 : ld_cnt_q;
  assign ld_wr = is_load & in_is_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_cnt_q <= '0;
      ld_cnt_q <= '0;
      rd_open_q <= 1'b0;
      op_we_q <= '0;
      op_last_q <= '0;
    end else begin
      r_cnt_q <= (unload_rd | op_rd) ? r_idx + 1'b1 : r_idx;
      ld_cnt_q <= ld_wr ? ld_idx + 1'b1 : ld_idx;
      rd_open_q <= rd_open & ~(op_rd & (r_idx == LAST_ROW));
      // Operation writes follow their read by the read latency
      op_we_q <= {op_we_q[LAT-2:0], op_rd};
      op_last_q <= {op_last_q[LAT-2:0], op_rd & (r_idx == LAST_ROW)};
    end
  end

  always_ff @(posedge clk) begin
    op_widx_q[0] <= r_idx;
    for (int i = 1; i < LAT; i++) begin
      op_widx_q[i] <= op_widx_q[i-1];
    end
  end

  assign mem.w_index = is_load ? ld_idx : op_widx_q[LAT-1];
  assign mem.w_c_en = (status.cur_cmd[CMD_IN_C] & in_is_ready) | op_we_q[LAT-1];
  assign mem.w_u_en = status.cur_cmd[CMD_IN_U] & in_is_ready;

  // Operations free both classes with their last write
  assign status.in_last = (ld_wr & (ld_idx == LAST_ROW)) | op_last_q[LAT-1];
  assign status.out_last = (unload_rd & (r_idx == LAST_ROW)) | op_last_q[LAT-1];
  assign in_is_last = (ld_wr & (ld_idx == LAST_ROW)) | (is_add & op_rd & (r_idx == LAST_ROW));

endmodule

// ==== source/mem_mul_cmd_pkg.sv ====
`include "mem_mul_consts.svh"

package mem_mul_cmd_pkg;

  ////////////////////
  // Command codes
  // Order fixes the bit position in the one-hot vector

  typedef enum logic [`MM_CMD_BITS-1:0] {
    // C = Encode(U) - C
    CMD_C_EQ_U_MIN_C = 3'd0,
    // C = Encode(U)
    CMD_C_EQ_U = 3'd1,
    // C += streamed rows
    CMD_C_ADD_IN = 3'd2,
    CMD_IN_C = 3'd3,
    // Only the low 16 bits of the bus are stored
    CMD_IN_U = 3'd4,
    CMD_OUT_C = 3'd5,
    CMD_OUT_U = 3'd6
  } cmd_code_e;

  // One bit per command, indexed by cmd_code_e
  typedef logic [`MM_CMD_COUNT-1:0] cmd_onehot_t;

endpackage

// ==== source/mem_mul_consts.svh ====
`ifndef MEM_MUL_CONSTS_SVH
`define MEM_MUL_CONSTS_SVH

// Data bus and row layout
`define MM_WORD_BITS 64
`define MM_LANES 4
`define MM_LANE_BITS 16
`define MM_U_BITS 4

// Matrix geometry
`define MM_ROWS 16
`define MM_INDEX_BITS 4

// Cycles from read index to read data
`define MM_READ_LATENCY 2

// Command encoding
`define MM_CMD_BITS 3
`define MM_CMD_COUNT 7

////////////////////
// Conflict classes, one bit per command code
// In class holds the loads, C-plus-equals and both encodes
`define MM_MASK_IN_CLASS 7'h1F
// Out class holds the unloads, C-plus-equals and both encodes
`define MM_MASK_OUT_CLASS 7'h67

`endif

// ==== source/mem_mul_data_pkg.sv ====
`include "mem_mul_consts.svh"

package mem_mul_data_pkg;

  // Full bus word, also one C row
  typedef logic [`MM_WORD_BITS-1:0] word_t;

  // One lane of a C row
  typedef logic [`MM_LANE_BITS-1:0] lane_t;

  // Single U value and a packed U row
  typedef logic [`MM_U_BITS-1:0] u_val_t;
  typedef logic [`MM_LANES*`MM_U_BITS-1:0] u_row_t;

  typedef logic [`MM_INDEX_BITS-1:0] row_index_t;

endpackage

// ==== source/mem_mul_ifs.sv ====
`timescale 1ns/1ps

// Running command and its class start and end pulses
interface cmd_status_if
  import mem_mul_cmd_pkg::*;
();
  cmd_onehot_t cur_cmd;
  logic in_first;
  logic out_first;
  logic in_last;
  logic out_last;

  modport dispatch (
    output cur_cmd, in_first, out_first,
    input in_last, out_last
  );

  modport worker (
    input cur_cmd, in_first, out_first,
    output in_last, out_last
  );

  modport monitor (
    input cur_cmd
  );
endinterface

// Row store access, one read port and one write port
interface row_mem_if
  import mem_mul_data_pkg::*;
();
  row_index_t r_index;
  logic r_c_sel;
  logic r_u_sel;
  row_index_t w_index;
  logic w_c_en;
  logic w_u_en;
  word_t w_c_data;
  u_row_t w_u_data;
  word_t r_c_data;
  u_row_t r_u_data;

  modport indexer (
    output r_index, r_c_sel, r_u_sel, w_index, w_c_en, w_u_en
  );

  modport arith (
    input r_c_data, r_u_data,
    output w_c_data, w_u_data
  );

  modport memory (
    input r_index, r_c_sel, r_u_sel, w_index, w_c_en, w_u_en, w_c_data, w_u_data,
    output r_c_data, r_u_data
  );
endinterface

// ==== source/mem_mul_top.sv ====
`timescale 1ns/1ps

module mem_mul_top
  import mem_mul_cmd_pkg::*;
  import mem_mul_data_pkg::*;
(
  input cmd_code_e cmd,
  input logic cmd_is_ready,
  output logic cmd_can_receive,
  input word_t in,
  input logic in_is_ready,
  output logic in_can_receive,
  output logic in_is_last,
  output word_t out,
  output logic out_is_ready,
  output logic out_is_last,
  input logic out_can_receive,
  input logic clk,
  input logic rst_n
);

  cmd_status_if status_bus ();
  row_mem_if mem_bus ();

  logic rd_is_ready;
  logic rd_is_last;
  word_t rd_data;

  cmd_dispatch u_dispatch (
    .clk(clk),
    .rst_n(rst_n),
    .cmd(cmd),
    .cmd_is_ready(cmd_is_ready),
    .cmd_can_receive(cmd_can_receive),
    .status(status_bus.dispatch)
  );

  index_handler u_index (
    .clk(clk),
    .rst_n(rst_n),
    .in_is_ready(in_is_ready),
    .out_can_receive(out_can_receive),
    .in_can_receive(in_can_receive),
    .in_is_last(in_is_last),
    .status(status_bus.worker),
    .mem(mem_bus.indexer)
  );

  row_memory u_memory (
    .clk(clk),
    .rst_n(rst_n),
    .mem(mem_bus.memory)
  );

  row_arith u_arith (
    .clk(clk),
    .rst_n(rst_n),
    .in(in),
    .in_is_ready(in_is_ready),
    .status(status_bus.monitor),
    .mem(mem_bus.arith)
  );

  ////////////////////
  // Unload row request and read data
  assign rd_is_ready = (status_bus.cur_cmd[CMD_OUT_C] | status_bus.cur_cmd[CMD_OUT_U])
                     & out_can_receive;
  assign rd_is_last = rd_is_ready & status_bus.out_last;
  // Unselected store reads back as zero
  assign rd_data = mem_bus.r_c_data | word_t'(mem_bus.r_u_data);

  out_adapter u_out (
    .clk(clk),
    .rst_n(rst_n),
    .out_can_receive(out_can_receive),
    .rd_is_ready(rd_is_ready),
    .rd_is_last(rd_is_last),
    .rd_data(rd_data),
    .out(out),
    .out_is_ready(out_is_ready),
    .out_is_last(out_is_last)
  );

endmodule

// ==== source/out_adapter.sv ====
`timescale 1ns/1ps
`include "mem_mul_consts.svh"

module out_adapter
  import mem_mul_data_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic out_can_receive,
  input logic rd_is_ready,
  input logic rd_is_last,
  input word_t rd_data,
  output word_t out,
  output logic out_is_ready,
  output logic out_is_last
);

  localparam int LAT = `MM_READ_LATENCY;

  logic [LAT-1:0] vld_q;
  logic [LAT-1:0] last_q;
  logic a_vld;
  logic a_last;
  logic [1:0] b_vld;
  logic [1:0] b_last;
  word_t b_data [2];
  logic [2:0] m_vld;
  logic [2:0] m_last;
  word_t m_data [3];

  // Request flags follow the read data
  assign a_vld = vld_q[LAT-1];
  assign a_last = last_q[LAT-1];

  ////////////////////
  // Buffered words first, then the arriving one
  always_comb begin
    m_vld[0] = b_vld[0] | a_vld;
    m_vld[1] = b_vld[1] | (b_vld[0] & a_vld);
    m_vld[2] = b_vld[0] & b_vld[1] & a_vld;
    m_last[0] = b_vld[0] ? b_last[0] : (a_vld & a_last);
    m_last[1] = b_vld[1] ? b_last[1] : (b_vld[0] & a_vld & a_last);
    m_last[2] = m_vld[2] & a_last;
    m_data[0] = b_vld[0] ? b_data[0] : rd_data;
    m_data[1] = b_vld[1] ? b_data[1] : rd_data;
    m_data[2] = rd_data;
  end

  assign out_is_ready = out_can_receive & m_vld[0];
  assign out_is_last = out_can_receive & m_last[0];
  assign out = out_can_receive ? m_data[0] : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
      last_q <= '0;
      b_vld <= '0;
      b_last <= '0;
    end else begin
      vld_q <= {vld_q[LAT-2:0], rd_is_ready};
      last_q <= {last_q[LAT-2:0], rd_is_last};
      // Shift out the head only when it was taken
      b_vld <= out_can_receive ? m_vld[2:1] : m_vld[1:0];
      b_last <= out_can_receive ? m_last[2:1] : m_last[1:0];
    end
  end

  always_ff @(posedge clk) begin
    b_data[0] <= out_can_receive ? m_data[1] : m_data[0];
    b_data[1] <= out_can_receive ? m_data[2] : m_data[1];
  end

endmodule

// ==== source/row_arith.sv ====
`timescale 1ns/1ps
`include "mem_mul_consts.svh"

module row_arith
  import mem_mul_cmd_pkg::*;
  import mem_mul_data_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input word_t in,
  input logic in_is_ready,
  cmd_status_if.monitor status,
  row_mem_if.arith mem
);

  localparam int LAT = `MM_READ_LATENCY;
  localparam int LB = `MM_LANE_BITS;
  localparam int UB = `MM_U_BITS;

  word_t in_q [LAT];
  logic [LAT-1:0] add_q;
  word_t enc_row;
  word_t add_row;
  word_t diff_row;

  // Input word lined up with the C read data
  always_ff @(posedge clk) begin
    if (in_is_ready) begin
      in_q[0] <= in;
    end
    for (int i = 1; i < LAT; i++) begin
      in_q[i] <= in_q[i-1];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      add_q <= '0;
    end else begin
      add_q <= {add_q[LAT-2:0], status.cur_cmd[CMD_C_ADD_IN] & in_is_ready};
    end
  end

  ////////////////////
  // Lane math, wraps modulo 2^16
  for (genvar j = 0; j < `MM_LANES; j++) begin : g_lane
    u_val_t u_val;
    lane_t c_lane;
    lane_t in_lane;
    lane_t enc_lane;

    assign u_val = mem.r_u_data[j*UB +: UB];
    assign c_lane = mem.r_c_data[j*LB +: LB];
    assign in_lane = in_q[LAT-1][j*LB +: LB];
    // U value sits in the top bits of the lane
    assign enc_lane = {u_val, {(LB-UB){1'b0}}};

    assign enc_row[j*LB +: LB] = enc_lane;
    assign diff_row[j*LB +: LB] = enc_lane - c_lane;
    assign add_row[j*LB +: LB] = c_lane + in_lane;
  end

  always_comb begin
    if (add_q[LAT-1]) begin
      mem.w_c_data = add_row;
    end else if (status.cur_cmd[CMD_C_EQ_U_MIN_C]) begin
      mem.w_c_data = diff_row;
    end else if (status.cur_cmd[CMD_C_EQ_U]) begin
      mem.w_c_data = enc_row;
    end else begin
      mem.w_c_data = in;
    end
  end

  assign mem.w_u_data = in[$bits(u_row_t)-1:0];

endmodule

// ==== source/row_memory.sv ====
`timescale 1ns/1ps
`include "mem_mul_consts.svh"

module row_memory
  import mem_mul_data_pkg::*;
(
  input logic clk,
  input logic rst_n,
  row_mem_if.memory mem
);

  localparam int LAT = `MM_READ_LATENCY;

  word_t c_mem [`MM_ROWS];
  u_row_t u_mem [`MM_ROWS];
  word_t c_rd_q [LAT];
  u_row_t u_rd_q [LAT];

  ////////////////////
  // Storage writes
  always_ff @(posedge clk) begin
    if (mem.w_c_en) begin
      c_mem[mem.w_index] <= mem.w_c_data;
    end
    if (mem.w_u_en) begin
      u_mem[mem.w_index] <= mem.w_u_data;
    end
  end

  // Read path, zero when the store was not selected
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < LAT; i++) begin
        c_rd_q[i] <= '0;
        u_rd_q[i] <= '0;
      end
    end else begin
      c_rd_q[0] <= mem.r_c_sel ? c_mem[mem.r_index] : '0;
      u_rd_q[0] <= mem.r_u_sel ? u_mem[mem.r_index] : '0;
      for (int i = 1; i < LAT; i++) begin
        c_rd_q[i] <= c_rd_q[i-1];
        u_rd_q[i] <= u_rd_q[i-1];
      end
    end
  end

  assign mem.r_c_data = c_rd_q[LAT-1];
  assign mem.r_u_data = u_rd_q[LAT-1];

endmodule

// ==== tb.f ====
+incdir+source
+incdir+bench
source/mem_mul_cmd_pkg.sv
source/mem_mul_data_pkg.sv
source/mem_mul_ifs.sv
source/cmd_dispatch.sv
source/index_handler.sv
source/row_memory.sv
source/row_arith.sv
source/out_adapter.sv
source/mem_mul_top.sv
bench/tb_mem_mul.sv
